//--- rtl/rv_macros.svh
//////////////////////////////////////////////////////////////////////
// Build parameters for the RV32I execute path. The datapath assumes
// XLEN is 32
//////////////////////////////////////////////////////////////////////
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Datapath width
`define XLEN 32

//////////////////////////////////////////////////////////////////////
// Major opcodes handled by this path
//////////////////////////////////////////////////////////////////////
`define OPC_OP    7'b0110011
`define OPC_OPIMM 7'b0010011
`define OPC_LUI   7'b0110111

`endif

//--- rtl/rv_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the execute path. The encodings of aluSel_t and
// insClass_t are fixed and also used by the testbench model
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "rv_macros.svh"

package rv_pkg;

    //////////////////////////////////////////////////////////////////////
    // Operation and class encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ADD,                                   // 0
        SUB,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        AND,
        OR,
        XOR,
        LUI                                    // 10
    } aluSel_t;

    typedef enum logic [1:0] {
        iType = 2'b11,
        rType = 2'b10,
        uType = 2'b01,
        noOp  = 2'b00
    } insClass_t;

    typedef enum logic [2:0] {
        f3AddSub = 3'd0,
        f3Sll    = 3'd1,
        f3Slt    = 3'd2,
        f3Sltu   = 3'd3,
        f3Xor    = 3'd4,
        f3SrlSra = 3'd5,
        f3Or     = 3'd6,
        f3And    = 3'd7
    } funct3_t;

    //////////////////////////////////////////////////////////////////////
    // Instruction word views
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        funct3_t     funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmt_t;

    typedef struct packed {
        logic [19:0] imm;                      // Goes to bits 31:12 of the result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFmt_t;

    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
        uFmt_t uFmt;
    } instr_t;

    //////////////////////////////////////////////////////////////////////
    // Pipeline bundles
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        aluSel_t            aluSel;
        logic               aluSrcImm;         // Selects imm over operandB in execute
        logic               writeEnable;
        logic               valid;
        logic [4:0]         rd;
        logic [`XLEN-1:0]   operandA;
        logic [`XLEN-1:0]   operandB;
        logic [`XLEN-1:0]   imm;
    } decodeStage_t;

    typedef struct packed {
        logic               valid;
        logic               writeEnable;       // Already qualified by valid
        logic [4:0]         rd;
        logic [`XLEN-1:0]   result;
    } execResult_t;

endpackage

`default_nettype wire

//--- rtl/aluControl.sv
//////////////////////////////////////////////////////////////////////
// ALU select decode. Unlisted funct3/funct7 combinations give ADD
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module aluControl (
    input  rv_pkg::insClass_t insClass,
    input  rv_pkg::funct3_t   funct3,
    input  logic [6:0]        funct7,
    output rv_pkg::aluSel_t   aluSel
);

    localparam logic [6:0] funct7Base = 7'd0;
    localparam logic [6:0] funct7Alt  = 7'd32;     // SUB and SRA

    always_comb begin
        aluSel = rv_pkg::ADD;                       // Fallback for every unmapped case

        case (insClass)
            rv_pkg::iType: begin
                // SLLI, SLTIU and the immediate shifts stay on ADD
                case (funct3)
                    rv_pkg::f3AddSub: aluSel = rv_pkg::ADD;
                    rv_pkg::f3Slt:    aluSel = rv_pkg::SLT;
                    rv_pkg::f3Xor:    aluSel = rv_pkg::XOR;
                    rv_pkg::f3Or:     aluSel = rv_pkg::OR;
                    rv_pkg::f3And:    aluSel = rv_pkg::AND;
                    default:          aluSel = rv_pkg::ADD;
                endcase
            end

            rv_pkg::rType: begin
                case (funct7)
                    funct7Base: begin
                        case (funct3)
                            rv_pkg::f3AddSub: aluSel = rv_pkg::ADD;
                            rv_pkg::f3Sll:    aluSel = rv_pkg::SLL;
                            rv_pkg::f3Slt:    aluSel = rv_pkg::SLT;
                            rv_pkg::f3Sltu:   aluSel = rv_pkg::SLTU;
                            rv_pkg::f3Xor:    aluSel = rv_pkg::XOR;
                            rv_pkg::f3SrlSra: aluSel = rv_pkg::SRL;
                            rv_pkg::f3Or:     aluSel = rv_pkg::OR;
                            rv_pkg::f3And:    aluSel = rv_pkg::AND;
                            default:          aluSel = rv_pkg::ADD;
                        endcase
                    end
                    funct7Alt: begin
                        case (funct3)
                            rv_pkg::f3AddSub: aluSel = rv_pkg::SUB;
                            rv_pkg::f3SrlSra: aluSel = rv_pkg::SRA;
                            default:          aluSel = rv_pkg::ADD;
                        endcase
                    end
                    default: aluSel = rv_pkg::ADD;
                endcase
            end

            rv_pkg::uType: aluSel = rv_pkg::LUI;
            default:       aluSel = rv_pkg::ADD;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mainDecoder.sv
//////////////////////////////////////////////////////////////////////
// Opcode decode. Only OP, OP-IMM and LUI are recognised
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module mainDecoder (
    input  logic [6:0]        opcode,
    output rv_pkg::insClass_t insClass,
    output logic              aluSrcImm,
    output logic              writeEnable
);

    //////////////////////////////////////////////////////////////////////
    // Instruction class
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (opcode)
            `OPC_OP:    insClass = rv_pkg::rType;
            `OPC_OPIMM: insClass = rv_pkg::iType;
            `OPC_LUI:   insClass = rv_pkg::uType;
            default:    insClass = rv_pkg::noOp;    // Loads, stores, branches and the rest
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath controls
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (insClass)
            rv_pkg::iType: begin
                aluSrcImm   = 1'b1;
                writeEnable = 1'b1;
            end
            rv_pkg::uType: begin
                aluSrcImm   = 1'b1;                 // LUI takes the U immediate as operandB
                writeEnable = 1'b1;
            end
            rv_pkg::rType: begin
                aluSrcImm   = 1'b0;
                writeEnable = 1'b1;
            end
            default: begin
                aluSrcImm   = 1'b0;
                writeEnable = 1'b0;                 // Unknown opcodes never write back
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/immGenerator.sv
//////////////////////////////////////////////////////////////////////
// Immediate build for I and U formats. The U form assumes XLEN is 32
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module immGenerator (
    input  rv_pkg::instr_t    instr,
    input  rv_pkg::insClass_t insClass,
    output logic [`XLEN-1:0]  imm
);

    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immU;

    // Sign bit of the I immediate is instruction bit 31
    assign immI = {{(`XLEN-12){instr.iFmt.imm[11]}}, instr.iFmt.imm};

    assign immU = {instr.uFmt.imm, 12'b0};

    always_comb begin
        case (insClass)
            rv_pkg::iType: imm = immI;
            rv_pkg::uType: imm = immU;
            default:       imm = '0;                // R type and unknown use no immediate
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
//////////////////////////////////////////////////////////////////////
// Integer ALU. Shifts use operandB[4:0] only, compares return 0 or 1
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module alu (
    input  rv_pkg::aluSel_t  aluSel,
    input  logic [`XLEN-1:0] operandA,
    input  logic [`XLEN-1:0] operandB,
    output logic [`XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = operandB[4:0];
    assign lessSigned   = $signed(operandA) < $signed(operandB);
    assign lessUnsigned = operandA < operandB;

    always_comb begin
        case (aluSel)
            rv_pkg::ADD:  result = operandA + operandB;
            rv_pkg::SUB:  result = operandA - operandB;
            rv_pkg::SLT:  result = {{(`XLEN-1){1'b0}}, lessSigned};
            rv_pkg::SLTU: result = {{(`XLEN-1){1'b0}}, lessUnsigned};
            rv_pkg::SLL:  result = operandA << shamt;
            rv_pkg::SRL:  result = operandA >> shamt;
            rv_pkg::SRA:  result = $unsigned($signed(operandA) >>> shamt);
            rv_pkg::AND:  result = operandA & operandB;
            rv_pkg::OR:   result = operandA | operandB;
            rv_pkg::XOR:  result = operandA ^ operandB;
            rv_pkg::LUI:  result = operandB;    // U immediate arrives already shifted
            default:      result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/executeStage.sv
//////////////////////////////////////////////////////////////////////
// Two-stage decode/execute path. No back-pressure, one instruction per
// cycle, result two edges after the instruction is sampled
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module executeStage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instrValid,
    input  rv_pkg::instr_t       instr,
    input  logic [`XLEN-1:0]     rs1Data,
    input  logic [`XLEN-1:0]     rs2Data,
    output rv_pkg::execResult_t  result
);

    rv_pkg::insClass_t    insClass;
    rv_pkg::aluSel_t      aluSel;
    logic                 aluSrcImm;
    logic                 decWriteEnable;
    logic [`XLEN-1:0]     imm;
    rv_pkg::decodeStage_t decodeNext;
    rv_pkg::decodeStage_t decodeReg;
    logic [`XLEN-1:0]     aluOperandB;
    logic [`XLEN-1:0]     aluResult;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////
    mainDecoder uMainDecoder (
        .opcode      (instr.rFmt.opcode),
        .insClass    (insClass),
        .aluSrcImm   (aluSrcImm),
        .writeEnable (decWriteEnable)
    );

    aluControl uAluControl (
        .insClass (insClass),
        .funct3   (instr.rFmt.funct3),
        .funct7   (instr.rFmt.funct7),
        .aluSel   (aluSel)
    );

    immGenerator uImmGenerator (
        .instr    (instr),
        .insClass (insClass),
        .imm      (imm)
    );

    always_comb begin
        decodeNext.aluSel      = aluSel;
        decodeNext.aluSrcImm   = aluSrcImm;
        decodeNext.writeEnable = decWriteEnable & instrValid;
        decodeNext.valid       = instrValid;
        decodeNext.rd          = instr.rFmt.rd;
        decodeNext.operandA    = rs1Data;
        decodeNext.operandB    = rs2Data;
        decodeNext.imm         = imm;
    end

    always_ff @(posedge clk) begin
        decodeReg <= decodeNext;
        if (reset) begin
            decodeReg.valid       <= 1'b0;
            decodeReg.writeEnable <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////////////////////////
    assign aluOperandB = decodeReg.aluSrcImm ? decodeReg.imm : decodeReg.operandB;

    alu uAlu (
        .aluSel   (decodeReg.aluSel),
        .operandA (decodeReg.operandA),
        .operandB (aluOperandB),
        .result   (aluResult)
    );

    always_ff @(posedge clk) begin
        result.valid       <= decodeReg.valid;
        result.writeEnable <= decodeReg.writeEnable;
        result.rd          <= decodeReg.rd;
        result.result      <= aluResult;
        if (reset) begin
            result.valid       <= 1'b0;
            result.writeEnable <= 1'b0;       // No write-back until a real instruction drains
        end
    end

endmodule

`default_nettype wire

//--- testbench/executeModel.svh
//////////////////////////////////////////////////////////////////////
// Reference model of the execute path, included inside the testbench
// module. Needs rv_macros.svh and rv_pkg to be compiled first
//////////////////////////////////////////////////////////////////////
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

function automatic rv_pkg::insClass_t modelClass(input logic [6:0] opcode);
    rv_pkg::insClass_t cls;
    if (opcode == `OPC_OP)
        cls = rv_pkg::rType;
    else if (opcode == `OPC_OPIMM)
        cls = rv_pkg::iType;
    else if (opcode == `OPC_LUI)
        cls = rv_pkg::uType;
    else
        cls = rv_pkg::noOp;
    return cls;
endfunction

function automatic rv_pkg::aluSel_t modelAluSel(input rv_pkg::insClass_t cls,
                                                input logic [2:0] f3,
                                                input logic [6:0] f7);
    rv_pkg::aluSel_t sel;
    sel = rv_pkg::ADD;
    if (cls == rv_pkg::uType) begin
        sel = rv_pkg::LUI;
    end else if (cls == rv_pkg::iType) begin
        case (f3)
            3'd2:    sel = rv_pkg::SLT;
            3'd4:    sel = rv_pkg::XOR;
            3'd6:    sel = rv_pkg::OR;
            3'd7:    sel = rv_pkg::AND;
            default: sel = rv_pkg::ADD;         // ADDI, SLLI, SLTIU and the shifts
        endcase
    end else if (cls == rv_pkg::rType && f7 == 7'd0) begin
        case (f3)
            3'd0: sel = rv_pkg::ADD;
            3'd1: sel = rv_pkg::SLL;
            3'd2: sel = rv_pkg::SLT;
            3'd3: sel = rv_pkg::SLTU;
            3'd4: sel = rv_pkg::XOR;
            3'd5: sel = rv_pkg::SRL;
            3'd6: sel = rv_pkg::OR;
            3'd7: sel = rv_pkg::AND;
        endcase
    end else if (cls == rv_pkg::rType && f7 == 7'd32) begin
        if (f3 == 3'd0)
            sel = rv_pkg::SUB;
        else if (f3 == 3'd5)
            sel = rv_pkg::SRA;
    end
    return sel;
endfunction

function automatic logic [`XLEN-1:0] modelAlu(input rv_pkg::aluSel_t sel,
                                              input logic [`XLEN-1:0] a,
                                              input logic [`XLEN-1:0] b);
    logic [4:0]       sh;
    logic [`XLEN-1:0] fill;
    logic [`XLEN-1:0] r;
    sh   = b[4:0];
    fill = a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0;   // Sign bits that SRA shifts in
    case (sel)
        rv_pkg::ADD:  r = a + b;
        rv_pkg::SUB:  r = a - b;
        rv_pkg::SLT:  r = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
        rv_pkg::SLTU: r = {{(`XLEN-1){1'b0}}, a < b};
        rv_pkg::SLL:  r = a << sh;
        rv_pkg::SRL:  r = a >> sh;
        rv_pkg::SRA:  r = (a >> sh) | fill;
        rv_pkg::AND:  r = a & b;
        rv_pkg::OR:   r = a | b;
        rv_pkg::XOR:  r = a ^ b;
        rv_pkg::LUI:  r = b;
        default:      r = '0;
    endcase
    return r;
endfunction

function automatic rv_pkg::execResult_t modelExecute(input logic valid,
                                                     input logic [31:0] word,
                                                     input logic [`XLEN-1:0] rs1,
                                                     input logic [`XLEN-1:0] rs2);
    rv_pkg::insClass_t   cls;
    logic [`XLEN-1:0]    immVal;
    logic [`XLEN-1:0]    opB;
    rv_pkg::execResult_t r;
    cls = modelClass(word[6:0]);
    if (cls == rv_pkg::iType)
        immVal = {{(`XLEN-12){word[31]}}, word[31:20]};
    else if (cls == rv_pkg::uType)
        immVal = {word[31:12], 12'h000};
    else
        immVal = '0;
    opB = (cls == rv_pkg::iType || cls == rv_pkg::uType) ? immVal : rs2;
    r.valid       = valid;
    r.writeEnable = valid & (cls != rv_pkg::noOp);
    r.rd          = word[11:7];
    r.result      = modelAlu(modelAluSel(cls, word[14:12], word[31:25]), rs1, opB);
    return r;
endfunction

`endif

//--- testbench/executeStageTb.sv
//////////////////////////////////////////////////////////////////////
// Random test of the execute path from a fixed seed. Expects two edges
// of latency from drive to result and no back-pressure
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module executeStageTb;

    localparam int numCycles   = 3000;
    localparam int waitTimeout = 8;

    logic                clk;
    logic                reset;
    logic                instrValid;
    rv_pkg::instr_t      instr;
    logic [`XLEN-1:0]    rs1Data;
    logic [`XLEN-1:0]    rs2Data;
    rv_pkg::execResult_t result;

    rv_pkg::execResult_t expQ[$];                   // Expected results in issue order
    logic [3:0]          classSeen;

    `include "executeModel.svh"

    executeStage uut (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic checkResult(input rv_pkg::execResult_t actual,
                               input rv_pkg::execResult_t expected);
        if (actual.valid !== expected.valid)
            reportFailure($sformatf("CHECK FAILED result.valid got %h expected %h",
                                    actual.valid, expected.valid));
        if (actual.writeEnable !== expected.writeEnable)
            reportFailure($sformatf("CHECK FAILED result.writeEnable got %h expected %h",
                                    actual.writeEnable, expected.writeEnable));
        if (expected.valid) begin                   // rd and result are free in empty slots
            if (actual.rd !== expected.rd)
                reportFailure($sformatf("CHECK FAILED result.rd got %h expected %h",
                                        actual.rd, expected.rd));
            if (actual.result !== expected.result)
                reportFailure($sformatf("CHECK FAILED result.result got %h expected %h",
                                        actual.result, expected.result));
        end
    endtask

    task automatic checkAluSel(input rv_pkg::aluSel_t actual, input rv_pkg::aluSel_t expected);
        if (actual !== expected)
            reportFailure($sformatf("CHECK FAILED uut.decodeReg.aluSel got %h expected %h",
                                    actual, expected));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic driveRandom(output logic valid, output rv_pkg::aluSel_t sel);
        logic [31:0]       word;
        logic [31:0]       raw;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
        rv_pkg::insClass_t cls;
        int                pick;
        word = $urandom;
        raw  = $urandom;
        pick = $urandom_range(0, 3);
        case (pick)
            0:       word[6:0] = `OPC_OP;
            1:       word[6:0] = `OPC_OPIMM;
            2:       word[6:0] = `OPC_LUI;
            default: word[6:0] = raw[6:0];          // Mostly opcodes outside this path
        endcase
        pick = $urandom_range(0, 7);
        if (pick < 3)
            word[31:25] = 7'd0;
        else if (pick < 6)
            word[31:25] = 7'd32;
        raw   = $urandom;
        valid = raw[0] | raw[1];                    // Gaps in about one cycle in four
        a     = $urandom;
        b     = (raw[4:2] == 3'd0) ? a : $urandom;  // Equal operands hit the compare edge
        cls   = modelClass(word[6:0]);
        sel   = modelAluSel(cls, word[14:12], word[31:25]);
        if (valid)
            classSeen[cls] = 1'b1;
        instrValid <= valid;
        instr      <= word;
        rs1Data    <= a;
        rs2Data    <= b;
        expQ.push_back(modelExecute(valid, word, a, b));
    endtask

    initial begin
        logic [31:0]         word;
        rv_pkg::execResult_t expFirst;
        logic                curValid;
        logic                prevValid;
        rv_pkg::aluSel_t     curSel;
        rv_pkg::aluSel_t     prevSel;
        int                  edges;

        reset      <= 1'b1;
        instrValid <= 1'b0;
        instr      <= '0;
        rs1Data    <= '0;
        rs2Data    <= '0;
        classSeen  = '0;
        prevValid  = 1'b0;
        prevSel    = rv_pkg::ADD;
        void'($urandom(3));

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // One LUI first to time the latency out of reset
        @(posedge clk);
        word = {20'hABCDE, 5'd7, `OPC_LUI};
        instrValid <= 1'b1;
        instr      <= word;
        rs1Data    <= 32'h1234_5678;
        rs2Data    <= 32'h0F0F_0F0F;
        expFirst   = modelExecute(1'b1, word, 32'h1234_5678, 32'h0F0F_0F0F);
        edges      = 0;
        @(negedge clk);
        while (result.valid !== 1'b1) begin
            checkResult(result, '0);                // Nothing may write back before the first result
            if (edges >= waitTimeout)
                reportFailure("No valid result came out after the first instruction");
            @(posedge clk);
            instrValid <= 1'b0;
            edges++;
            @(negedge clk);
        end
        if (edges != 2)
            reportFailure($sformatf("First result took %0d clock edges instead of 2", edges));
        checkResult(result, expFirst);

        // The two stages hold no valid instruction when the random run starts
        expQ.push_back('0);
        expQ.push_back('0);

        for (int i = 0; i < numCycles; i++) begin
            @(posedge clk);
            driveRandom(curValid, curSel);
            @(negedge clk);
            if (prevValid)
                checkAluSel(uut.decodeReg.aluSel, prevSel);
            checkResult(result, expQ.pop_front());
            prevValid = curValid;
            prevSel   = curSel;
        end

        repeat (2) begin
            @(posedge clk);
            instrValid <= 1'b0;
            @(negedge clk);
            checkResult(result, expQ.pop_front());
        end

        if (classSeen != 4'b1111)
            reportFailure("Random stimulus did not reach every instruction class");
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
+incdir+testbench
rtl/rv_pkg.sv
rtl/aluControl.sv
rtl/mainDecoder.sv
rtl/immGenerator.sv
rtl/alu.sv
rtl/executeStage.sv
testbench/executeStageTb.sv

//--- run.sh
#!/bin/sh
# Builds the execute path testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module executeStageTb -o executeStageSim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/executeStageSim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log

grep -qx "TB PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
